/* sim/arbiter_testdata.txt */
// gen_end gen_id word_id char0..char7 match hash_num, all hex
// three packets, gen_end of the first two falls mid-batch
0 0000a001 0001 70 61 73 73 77 6f 72 64 0 00
0 0000a001 0002 6c 65 74 6d 65 69 6e 31 0 00
0 0000a001 0003 64 72 61 67 6f 6e 39 39 1 03
0 0000a001 0004 73 75 6e 73 68 69 6e 65 0 00
0 0000a001 0005 6d 6f 6e 6b 65 79 31 32 0 00
1 0000a001 0006 71 77 65 72 74 79 37 37 1 11
0 0000b002 0001 66 6f 6f 74 62 61 6c 6c 0 00
0 0000b002 0002 73 68 61 64 6f 77 34 32 0 00
0 0000b002 0003 6d 61 73 74 65 72 30 31 0 00
0 0000b002 0004 68 75 6e 74 65 72 32 78 0 00
1 0000b002 0005 74 72 75 73 74 6e 6f 31 1 2a
0 0000c003 0001 62 61 74 6d 61 6e 35 35 1 07
0 0000c003 0002 69 6c 6f 76 65 79 6f 75 0 00
1 0000c003 0003 77 65 6c 63 6f 6d 65 39 0 00

/* src.f */
rtl/arb_pkg.sv
rtl/cand_fifo.sv
rtl/batch_dispatch.sv
rtl/cand_id_ram.sv
rtl/result_collect.sv
rtl/arbiter_top.sv
sim/tb_clkgen.sv
sim/core_model.sv
sim/arbiter_assert.sv
sim/tb_arbiter.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_arbiter
FILELIST  = src.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Test completed successfully
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_arbiter.sv */
`timescale 1ns/1ps

module tb_arbiter import arb_pkg::*; ();

	localparam int          NUM_CORES     = 2;
	localparam int          NUM_INSTANCES = 4;
	localparam int          NUM_BATCHES   = 2;
	localparam int          FIFO_AW       = 3;
	localparam int          NUM_LINES     = 14;
	localparam int          FIELDS        = 13;
	localparam int          WAIT_LIMIT    = 2000;
	localparam int          HOLD_CYCLES   = 8;
	localparam int          WATCHDOG_NS   = 400000;
	localparam int unsigned SEED          = 32'ha420_d764;

	logic                          CORE_CLK;
	logic                          rst_n;
	cand_t                         cand;
	logic                          wr_en;
	logic                          full;
	match_rec_t                    match;
	logic                          empty;
	logic                          rd_en;
	logic                          idle;
	logic                          err_ram;
	logic [NUM_CORES-1:0]          core_ready;
	logic [NUM_CORES-1:0]          core_wr_en;
	core_cmd_e                     core_cmd;
	core_word_u                    core_din;
	core_result_t [NUM_CORES-1:0]  core_res;
	logic [NUM_CORES-1:0]          core_res_valid;
	logic [NUM_CORES-1:0]          core_res_ack;

	// raw data file tokens with FIELDS per line
	logic [31:0]  tdata [NUM_LINES*FIELDS];
	match_rec_t   exp_recs [$];
	bit           exp_used [$];

	tb_clkgen #(.PERIOD_NS(40), .RST_CYCLES(2)) u_clk (
		.CORE_CLK(CORE_CLK),
		.rst_n(rst_n)
	);

	arbiter_top #(
		.NUM_CORES(NUM_CORES),
		.NUM_INSTANCES(NUM_INSTANCES),
		.NUM_BATCHES(NUM_BATCHES),
		.FIFO_AW(FIFO_AW)
	) UUT (
		.CORE_CLK(CORE_CLK),
		.rst_n(rst_n),
		.cand(cand),
		.wr_en(wr_en),
		.full(full),
		.match(match),
		.empty(empty),
		.rd_en(rd_en),
		.idle(idle),
		.err_ram(err_ram),
		.core_ready(core_ready),
		.core_wr_en(core_wr_en),
		.core_cmd(core_cmd),
		.core_din(core_din),
		.core_res(core_res),
		.core_res_valid(core_res_valid),
		.core_res_ack(core_res_ack)
	);

	core_model #(
		.NUM_CORES(NUM_CORES),
		.NUM_INSTANCES(NUM_INSTANCES),
		.NUM_BATCHES(NUM_BATCHES),
		.NUM_LINES(NUM_LINES),
		.FIELDS(FIELDS),
		.SEED(SEED)
	) u_cores (
		.CORE_CLK(CORE_CLK),
		.rst_n(rst_n),
		.core_wr_en(core_wr_en),
		.core_cmd(core_cmd),
		.core_din(core_din),
		.core_ready(core_ready),
		.core_res(core_res),
		.core_res_valid(core_res_valid),
		.core_res_ack(core_res_ack)
	);

	// ************************************************************
	// error handling and compares
	// ************************************************************
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_match(input string name, input match_rec_t exp, input match_rec_t act);
		if (act !== exp)
			abort_run($sformatf("ERR %s expected gen %h word %h hash %h got gen %h word %h hash %h",
				name, exp.gen_id, exp.word_id, exp.hash_num,
				act.gen_id, act.word_id, act.hash_num));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("ERR %s expected %b got %b", name, exp, act));
	endtask

	function automatic cand_t cand_from_line(input int l);
		cand_t c;
		int b;
		b = l * FIELDS;
		c.gen_end = tdata[b][0];
		c.gen_id  = tdata[b+1];
		c.word_id = tdata[b+2][WORD_ID_W-1:0];
		for (int i = 0; i < NUM_CHARS; i++)
			c.chars[i] = tdata[b+3+i][7:0];
		return c;
	endfunction

	// records are matched as a set since order across cores is free
	task automatic check_record(input match_rec_t act);
		int idx;
		idx = -1;
		for (int i = 0; i < exp_recs.size(); i++)
			if (!exp_used[i] && exp_recs[i].gen_id == act.gen_id
				&& exp_recs[i].word_id == act.word_id)
				idx = i;
		if (idx < 0) begin
			abort_run($sformatf("unexpected match record for gen %h word %h",
				act.gen_id, act.word_id));
		end else begin
			check_match("match record", exp_recs[idx], act);
			exp_used[idx] = 1'b1;
		end
	endtask

	// ************************************************************
	// bounded waits
	// ************************************************************
	task automatic wait_reset();
		int n;
		n = 0;
		// sampled on the edge while rst_n moves 2 ns later
		while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
			@(posedge CORE_CLK);
			n++;
		end
		if (rst_n !== 1'b1)
			abort_run("reset was never released");
		#2;
	endtask

	task automatic wait_record();
		int n;
		n = 0;
		while (empty !== 1'b0 && n < WAIT_LIMIT) begin
			@(posedge CORE_CLK);
			#2;
			n++;
		end
		if (empty !== 1'b0)
			abort_run("timeout waiting for a match record");
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (idle !== 1'b1 && n < WAIT_LIMIT) begin
			@(posedge CORE_CLK);
			#2;
			n++;
		end
		if (idle !== 1'b1)
			abort_run("timeout waiting for the arbiter to go idle");
	endtask

	// ************************************************************
	// producer and consumer
	// ************************************************************
	task automatic send_all();
		int n;
		for (int l = 0; l < NUM_LINES; l++) begin
			n = 0;
			while (full && n < WAIT_LIMIT) begin
				wr_en = 1'b0;
				@(posedge CORE_CLK);
				#2;
				n++;
			end
			if (full)
				abort_run("timeout waiting for room in the input FIFO");
			cand  = cand_from_line(l);
			wr_en = 1'b1;
			@(posedge CORE_CLK);
			#2;
		end
		wr_en = 1'b0;
	endtask

	task automatic collect_all();
		match_rec_t held;
		for (int got = 0; got < exp_recs.size(); got++) begin
			wait_record();
			// first record held back to exercise back-pressure
			if (got == 0) begin
				held = match;
				for (int k = 0; k < HOLD_CYCLES; k++) begin
					@(posedge CORE_CLK);
					#2;
					check_flag("hold empty", 1'b0, empty);
					check_match("hold stable", held, match);
				end
			end
			check_record(match);
			rd_en = 1'b1;
			@(posedge CORE_CLK);
			#2;
			rd_en = 1'b0;
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		abort_run("simulation ran past its time limit");
	end

	initial begin
		match_rec_t r;
		int b;
		cand   = '0;
		wr_en  = 1'b0;
		rd_en  = 1'b0;
		$readmemh("sim/arbiter_testdata.txt", tdata);
		for (int l = 0; l < NUM_LINES; l++) begin
			b = l * FIELDS;
			if (tdata[b+11][0]) begin
				r.gen_id   = tdata[b+1];
				r.word_id  = tdata[b+2][WORD_ID_W-1:0];
				r.hash_num = tdata[b+12][HASH_NUM_W-1:0];
				exp_recs.push_back(r);
				exp_used.push_back(1'b0);
			end
		end

		wait_reset();
		check_flag("reset empty", 1'b1, empty);
		check_flag("reset idle", 1'b1, idle);
		check_flag("reset full", 1'b0, full);
		check_flag("reset core_wr_en", 1'b0, |core_wr_en);
		check_flag("reset err_ram", 1'b0, err_ram);

		fork
			send_all();
			collect_all();
		join

		// last record lands 2 cycles after its ack
		wait_idle();
		repeat (3) @(posedge CORE_CLK);
		#2;
		check_flag("final empty", 1'b1, empty);
		check_flag("final idle", 1'b1, idle);
		check_flag("final err_ram", 1'b0, err_ram);

		if (UUT.u_assert.n_err == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			abort_run("bound assertions reported errors during the run");
		end
	end

endmodule

/* sim/arbiter_assert.sv */
`timescale 1ns/1ps

module arbiter_assert import arb_pkg::*; #(
	parameter int NUM_CORES = 2
) (
	input logic                  CORE_CLK,
	input logic                  rst_n,
	input logic [NUM_CORES-1:0]  core_wr_en,
	input core_cmd_e             core_cmd,
	input match_rec_t            match,
	input logic                  empty,
	input logic                  rd_en,
	input logic                  full
);

	// failed assertions so far
	int n_err = 0;

	// one core written at a time
	wr_onehot: assert property (@(posedge CORE_CLK) disable iff (!rst_n)
		$onehot0(core_wr_en))
		else begin
			n_err++;
			$error("core_wr_en has more than one bit set");
		end

	// the start word closes the batch and no write follows it
	wr_gap: assert property (@(posedge CORE_CLK) disable iff (!rst_n)
		(|core_wr_en && core_cmd == CMD_START) |=> (core_wr_en == '0))
		else begin
			n_err++;
			$error("core write issued outside a batch");
		end

	// pending record holds until consumed
	match_hold: assert property (@(posedge CORE_CLK) disable iff (!rst_n)
		(!empty && !rd_en) |=> (!empty && $stable(match)))
		else begin
			n_err++;
			$error("match record changed before it was read");
		end

	flags_known: assert property (@(posedge CORE_CLK) disable iff (!rst_n)
		!$isunknown({full, empty}))
		else begin
			n_err++;
			$error("full or empty is unknown");
		end

endmodule

bind arbiter_top arbiter_assert #(.NUM_CORES(NUM_CORES)) u_assert (
	.CORE_CLK(CORE_CLK),
	.rst_n(rst_n),
	.core_wr_en(core_wr_en),
	.core_cmd(core_cmd),
	.match(match),
	.empty(empty),
	.rd_en(rd_en),
	.full(full)
);

/* sim/core_model.sv */
`timescale 1ns/1ps

module core_model import arb_pkg::*; #(
	parameter int          NUM_CORES     = 2,
	parameter int          NUM_INSTANCES = 4,
	parameter int          NUM_BATCHES   = 2,
	parameter int          NUM_LINES     = 14,
	parameter int          FIELDS        = 13,
	parameter int unsigned SEED          = 32'h1
) (
	input  logic                          CORE_CLK,
	input  logic                          rst_n,
	input  logic [NUM_CORES-1:0]          core_wr_en,
	input  core_cmd_e                     core_cmd,
	input  core_word_u                    core_din,
	output logic [NUM_CORES-1:0]          core_ready,
	output core_result_t [NUM_CORES-1:0]  core_res,
	output logic [NUM_CORES-1:0]          core_res_valid,
	input  logic [NUM_CORES-1:0]          core_res_ack
);

	// match table with one row per data file line
	logic [31:0]            tdata [NUM_LINES*FIELDS];
	logic [KEY_W-1:0]       tbl_key [NUM_LINES];
	logic                   tbl_match [NUM_LINES];
	logic [HASH_NUM_W-1:0]  tbl_hash [NUM_LINES];

	// per core key slots of the batch being written
	logic [KEY_W-1:0]       keys [NUM_CORES][NUM_INSTANCES];
	logic                   kval [NUM_CORES][NUM_INSTANCES];
	int                     widx [NUM_CORES];
	logic                   writing [NUM_CORES];

	// per core result queue with the head at index 0
	core_result_t           pend_res [NUM_CORES][NUM_BATCHES];
	longint                 pend_due [NUM_CORES][NUM_BATCHES];
	int                     pend_cnt [NUM_CORES];
	longint                 cycle;

	task automatic load_table();
		int b;
		$readmemh("sim/arbiter_testdata.txt", tdata);
		for (int l = 0; l < NUM_LINES; l++) begin
			b = l * FIELDS;
			// low 7 bits of each character with the first character lowest
			for (int i = 0; i < NUM_CHARS; i++)
				tbl_key[l][7*i +: 7] = tdata[b+3+i][6:0];
			tbl_match[l] = tdata[b+11][0];
			tbl_hash[l]  = tdata[b+12][HASH_NUM_W-1:0];
		end
	endtask

	function automatic int find_line(input logic [KEY_W-1:0] key);
		int hit;
		hit = -1;
		for (int l = NUM_LINES - 1; l >= 0; l--)
			if (tbl_match[l] && tbl_key[l] == key)
				hit = l;
		return hit;
	endfunction

	// first valid instance that hits the table wins
	function automatic core_result_t result_for(input int c, input logic [BATCH_W-1:0] batch);
		core_result_t r;
		int l;
		r = '0;
		r.batch = batch;
		for (int i = NUM_INSTANCES - 1; i >= 0; i--) begin
			l = find_line(keys[c][i]);
			if (kval[c][i] && l >= 0) begin
				r.equal    = 1'b1;
				r.inst     = INST_W'(i);
				r.hash_num = tbl_hash[l];
			end
		end
		return r;
	endfunction

	task automatic clear_cores();
		for (int c = 0; c < NUM_CORES; c++) begin
			widx[c]     = 0;
			writing[c]  = 1'b0;
			pend_cnt[c] = 0;
			for (int i = 0; i < NUM_INSTANCES; i++)
				kval[c][i] = 1'b0;
		end
	endtask

	task automatic pop_result(input int c);
		for (int k = 0; k < NUM_BATCHES - 1; k++) begin
			pend_res[c][k] = pend_res[c][k+1];
			pend_due[c][k] = pend_due[c][k+1];
		end
		pend_cnt[c]--;
	endtask

	task automatic take_write(input int c);
		if (core_cmd == CMD_KEY) begin
			if (widx[c] < NUM_INSTANCES) begin
				keys[c][widx[c]] = core_din.key.key;
				kval[c][widx[c]] = core_din.key.key_valid;
				widx[c]++;
			end
			writing[c] = 1'b1;
		end else begin
			// a start word schedules the answer 2 to 20 cycles out
			if (pend_cnt[c] < NUM_BATCHES) begin
				pend_res[c][pend_cnt[c]] = result_for(c, core_din.start.batch);
				pend_due[c][pend_cnt[c]] = cycle + 2 + longint'($urandom % 19);
				pend_cnt[c]++;
			end
			widx[c]    = 0;
			writing[c] = 1'b0;
		end
	endtask

	task automatic drive_outputs();
		for (int c = 0; c < NUM_CORES; c++) begin
			// room for a whole batch counting the one being written
			core_ready[c]     = (pend_cnt[c] + (writing[c] ? 1 : 0)) < NUM_BATCHES;
			core_res_valid[c] = (pend_cnt[c] > 0) && (cycle >= pend_due[c][0]);
			core_res[c]       = pend_res[c][0];
		end
	endtask

	initial begin
		core_ready     = '0;
		core_res       = '0;
		core_res_valid = '0;
		cycle          = 0;
		void'($urandom(SEED));
		load_table();
		clear_cores();
		forever begin
			@(posedge CORE_CLK);
			cycle++;
			if (rst_n !== 1'b1) begin
				clear_cores();
			end else begin
				for (int c = 0; c < NUM_CORES; c++) begin
					if (core_res_ack[c] && pend_cnt[c] > 0)
						pop_result(c);
					if (core_wr_en[c])
						take_write(c);
				end
			end
			#2;
			drive_outputs();
		end
	end

endmodule

/* sim/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS  = 40,
	parameter int RST_CYCLES = 2
) (
	output logic CORE_CLK,
	output logic rst_n
);

	initial begin
		CORE_CLK = 1'b0;
		forever #(PERIOD_NS / 2) CORE_CLK = ~CORE_CLK;
	end

	// release lands 2 ns after an edge, same as the rest of the stimulus
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge CORE_CLK);
		#2;
		rst_n = 1'b1;
	end

endmodule

/* rtl/arbiter_top.sv */
`timescale 1ns/1ps

module arbiter_top import arb_pkg::*; #(
	parameter int NUM_CORES     = 2,
	parameter int NUM_INSTANCES = 4,
	parameter int NUM_BATCHES   = 2,
	parameter int FIFO_AW       = 3
) (
	input  logic                          CORE_CLK,
	input  logic                          rst_n,
	// candidate input
	input  cand_t                         cand,
	input  logic                          wr_en,
	output logic                          full,
	// match output
	output match_rec_t                    match,
	output logic                          empty,
	input  logic                          rd_en,
	// status
	output logic                          idle,
	output logic                          err_ram,
	// core write side
	input  logic [NUM_CORES-1:0]          core_ready,
	output logic [NUM_CORES-1:0]          core_wr_en,
	output core_cmd_e                     core_cmd,
	output core_word_u                    core_din,
	// core read side
	input  core_result_t [NUM_CORES-1:0]  core_res,
	input  logic [NUM_CORES-1:0]          core_res_valid,
	output logic [NUM_CORES-1:0]          core_res_ack
);

	localparam int CORE_W    = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;
	localparam int RAM_DEPTH = NUM_CORES * NUM_BATCHES * NUM_INSTANCES;
	localparam int RAM_AW    = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;
	// room for every batch in flight plus the one being written
	localparam int CNT_W     = $clog2(NUM_CORES * NUM_BATCHES + 2);

	cand_t              fifo_dout;
	logic               fifo_empty;
	logic               fifo_rd;
	logic               ram_we;
	logic [RAM_AW-1:0]  ram_waddr;
	logic [RAM_AW-1:0]  ram_raddr;
	id_entry_t          ram_wdata;
	id_entry_t          ram_rdata;
	logic               batch_started;
	logic               batch_done;
	logic [CNT_W-1:0]   outstanding;

	cand_fifo #(
		.FIFO_AW(FIFO_AW)
	) u_fifo (
		.CORE_CLK(CORE_CLK),
		.rst_n(rst_n),
		.din(cand),
		.wr_en(wr_en),
		.full(full),
		.dout(fifo_dout),
		.rd_en(fifo_rd),
		.empty(fifo_empty)
	);

	batch_dispatch #(
		.NUM_CORES(NUM_CORES),
		.NUM_INSTANCES(NUM_INSTANCES),
		.NUM_BATCHES(NUM_BATCHES),
		.CORE_W(CORE_W),
		.RAM_AW(RAM_AW)
	) u_dispatch (
		.CORE_CLK(CORE_CLK),
		.rst_n(rst_n),
		.cand(fifo_dout),
		.cand_empty(fifo_empty),
		.cand_rd(fifo_rd),
		.core_ready(core_ready),
		.core_wr_en(core_wr_en),
		.core_cmd(core_cmd),
		.core_din(core_din),
		.ram_we(ram_we),
		.ram_waddr(ram_waddr),
		.ram_wdata(ram_wdata),
		.batch_started(batch_started)
	);

	cand_id_ram #(
		.RAM_DEPTH(RAM_DEPTH),
		.RAM_AW(RAM_AW)
	) u_ram (
		.CORE_CLK(CORE_CLK),
		.we(ram_we),
		.waddr(ram_waddr),
		.wdata(ram_wdata),
		.raddr(ram_raddr),
		.rdata(ram_rdata)
	);

	result_collect #(
		.NUM_CORES(NUM_CORES),
		.NUM_INSTANCES(NUM_INSTANCES),
		.NUM_BATCHES(NUM_BATCHES),
		.CORE_W(CORE_W),
		.RAM_AW(RAM_AW)
	) u_collect (
		.CORE_CLK(CORE_CLK),
		.rst_n(rst_n),
		.core_res(core_res),
		.core_res_valid(core_res_valid),
		.core_res_ack(core_res_ack),
		.ram_raddr(ram_raddr),
		.ram_rdata(ram_rdata),
		.match(match),
		.empty(empty),
		.rd_en(rd_en),
		.batch_done(batch_done),
		.err_ram(err_ram)
	);

	// ************************************************************
	// outstanding batches
	// ************************************************************
	// counted from batch start, so a batch being written also counts
	always_ff @(posedge CORE_CLK) begin
		if (!rst_n)
			outstanding <= '0;
		else if (batch_started && !batch_done)
			outstanding <= outstanding + 1'b1;
		else if (!batch_started && batch_done)
			outstanding <= outstanding - 1'b1;
	end

	assign idle = fifo_empty && (outstanding == '0);

endmodule

/* rtl/result_collect.sv */
`timescale 1ns/1ps

module result_collect import arb_pkg::*; #(
	parameter int NUM_CORES     = 2,
	parameter int NUM_INSTANCES = 4,
	parameter int NUM_BATCHES   = 2,
	parameter int CORE_W        = 1,
	parameter int RAM_AW        = 4
) (
	input  logic                          CORE_CLK,
	input  logic                          rst_n,
	input  core_result_t [NUM_CORES-1:0]  core_res,
	input  logic [NUM_CORES-1:0]          core_res_valid,
	output logic [NUM_CORES-1:0]          core_res_ack,
	output logic [RAM_AW-1:0]             ram_raddr,
	input  id_entry_t                     ram_rdata,
	output match_rec_t                    match,
	output logic                          empty,
	input  logic                          rd_en,
	output logic                          batch_done,
	output logic                          err_ram
);

	typedef enum logic [1:0] {
		R_POLL,
		R_LOOKUP,
		R_OUT
	} state_e;

	state_e                  state;
	logic [CORE_W-1:0]       rd_core;
	logic [CORE_W-1:0]       rd_core_next;
	core_result_t            polled;
	logic                    hit;
	logic [HASH_NUM_W-1:0]   hash_r;

	assign polled = core_res[rd_core];
	assign hit = (state == R_POLL) && core_res_valid[rd_core];
	assign rd_core_next = (rd_core == CORE_W'(NUM_CORES - 1)) ? '0 : rd_core + 1'b1;

	// pop the polled result in the same cycle it is seen
	assign core_res_ack = hit ? (NUM_CORES'(1) << rd_core) : '0;
	assign batch_done = hit;

	// ram read issued with the ack, data back next cycle
	assign ram_raddr = RAM_AW'(rd_core * (NUM_BATCHES * NUM_INSTANCES)
		+ polled.batch * NUM_INSTANCES + polled.inst);

	// ************************************************************
	// poll / lookup / output FSM
	// ************************************************************
	always_ff @(posedge CORE_CLK) begin
		if (!rst_n) begin
			state   <= R_POLL;
			rd_core <= '0;
			empty   <= 1'b1;
			err_ram <= 1'b0;
		end else begin
			case (state)
			R_POLL: begin
				if (hit && polled.equal)
					state <= R_LOOKUP;
				else
					rd_core <= rd_core_next;
			end
			R_LOOKUP: begin
				// matched row must hold a real candidate
				if (!ram_rdata.key_valid)
					err_ram <= 1'b1;
				empty <= 1'b0;
				state <= R_OUT;
			end
			R_OUT: begin
				// hold record until consumed, no more acks meanwhile
				if (rd_en && !empty) begin
					empty   <= 1'b1;
					rd_core <= rd_core_next;
					state   <= R_POLL;
				end
			end
			default: state <= R_POLL;
			endcase
		end
	end

	// payload
	always_ff @(posedge CORE_CLK) begin
		if (hit)
			hash_r <= polled.hash_num;
		if (state == R_LOOKUP) begin
			match.gen_id   <= ram_rdata.gen_id;
			match.word_id  <= ram_rdata.word_id;
			match.hash_num <= hash_r;
		end
	end

endmodule

/* rtl/cand_id_ram.sv */
`timescale 1ns/1ps

module cand_id_ram import arb_pkg::*; #(
	parameter int RAM_DEPTH = 16,
	parameter int RAM_AW    = 4
) (
	input  logic               CORE_CLK,
	input  logic               we,
	input  logic [RAM_AW-1:0]  waddr,
	input  id_entry_t          wdata,
	input  logic [RAM_AW-1:0]  raddr,
	output id_entry_t          rdata
);

	id_entry_t mem [RAM_DEPTH];

	// every row starts out invalid
	initial begin
		for (int i = 0; i < RAM_DEPTH; i++)
			mem[i] = '0;
	end

	// simple dual port, registered read
	always @(posedge CORE_CLK) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

endmodule

/* rtl/batch_dispatch.sv */
`timescale 1ns/1ps

module batch_dispatch import arb_pkg::*; #(
	parameter int NUM_CORES     = 2,
	parameter int NUM_INSTANCES = 4,
	parameter int NUM_BATCHES   = 2,
	parameter int CORE_W        = 1,
	parameter int RAM_AW        = 4
) (
	input  logic                  CORE_CLK,
	input  logic                  rst_n,
	input  cand_t                 cand,
	input  logic                  cand_empty,
	output logic                  cand_rd,
	input  logic [NUM_CORES-1:0]  core_ready,
	output logic [NUM_CORES-1:0]  core_wr_en,
	output core_cmd_e             core_cmd,
	output core_word_u            core_din,
	output logic                  ram_we,
	output logic [RAM_AW-1:0]     ram_waddr,
	output id_entry_t             ram_wdata,
	output logic                  batch_started
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WRITE,
		S_START
	} state_e;

	state_e              state;
	logic [CORE_W-1:0]   core_num;
	logic [INST_W-1:0]   inst_num;
	logic [BATCH_W-1:0]  batch_num [NUM_CORES];
	// gen_end seen, rest of this batch is padding
	logic                pad;
	logic                go;
	logic                take;
	logic [KEY_W-1:0]    key;
	core_word_u          din_next;

	// start a batch only with data waiting and the core able to take it all
	assign go = (state == S_IDLE) && !cand_empty && core_ready[core_num];
	// a key slot takes a fifo word unless padding or the fifo ran dry
	assign take = (state == S_WRITE) && !pad && !cand_empty;
	assign cand_rd = take;
	assign batch_started = go;

	// 7-bit ascii to key, msb of each character dropped
	always_comb begin
		for (int i = 0; i < NUM_CHARS; i++)
			key[7*i +: 7] = cand.chars[i][6:0];
	end

	// ************************************************************
	// batch FSM
	// ************************************************************
	always_ff @(posedge CORE_CLK) begin
		if (!rst_n) begin
			state    <= S_IDLE;
			core_num <= '0;
			inst_num <= '0;
			pad      <= 1'b0;
			for (int c = 0; c < NUM_CORES; c++)
				batch_num[c] <= '0;
		end else begin
			case (state)
			S_IDLE: begin
				if (go) begin
					inst_num <= '0;
					pad      <= 1'b0;
					state    <= S_WRITE;
				end
			end
			S_WRITE: begin
				if (take && cand.gen_end)
					pad <= 1'b1;
				inst_num <= inst_num + 1'b1;
				if (inst_num == INST_W'(NUM_INSTANCES - 1))
					state <= S_START;
			end
			S_START: begin
				// batch number wraps per core
				batch_num[core_num] <= (batch_num[core_num] == BATCH_W'(NUM_BATCHES - 1)) ?
					'0 : batch_num[core_num] + 1'b1;
				core_num <= (core_num == CORE_W'(NUM_CORES - 1)) ? '0 : core_num + 1'b1;
				state    <= S_IDLE;
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	// ************************************************************
	// core writes, one cycle behind the FSM
	// ************************************************************
	always_comb begin
		if (state == S_START) begin
			din_next.start.zero  = '0;
			din_next.start.batch = batch_num[core_num];
		end else begin
			din_next.key.key_valid = take;
			din_next.key.key       = key;
		end
	end

	always_ff @(posedge CORE_CLK) begin
		if (!rst_n) begin
			core_wr_en <= '0;
			core_cmd   <= CMD_KEY;
		end else begin
			if (state == S_WRITE || state == S_START)
				core_wr_en <= NUM_CORES'(1) << core_num;
			else
				core_wr_en <= '0;
			core_cmd <= (state == S_START) ? CMD_START : CMD_KEY;
		end
	end

	always_ff @(posedge CORE_CLK) begin
		core_din <= din_next;
	end

	// ID row per key slot, row = core, batch, instance
	assign ram_we = (state == S_WRITE);
	assign ram_waddr = RAM_AW'(core_num * (NUM_BATCHES * NUM_INSTANCES)
		+ batch_num[core_num] * NUM_INSTANCES + inst_num);

	always_comb begin
		ram_wdata.key_valid = take;
		ram_wdata.gen_id    = cand.gen_id;
		ram_wdata.word_id   = cand.word_id;
	end

endmodule

/* rtl/cand_fifo.sv */
`timescale 1ns/1ps

module cand_fifo import arb_pkg::*; #(
	parameter int FIFO_AW = 3
) (
	input  logic   CORE_CLK,
	input  logic   rst_n,
	input  cand_t  din,
	input  logic   wr_en,
	output logic   full,
	output cand_t  dout,
	input  logic   rd_en,
	output logic   empty
);

	localparam int DEPTH = 1 << FIFO_AW;

	cand_t mem [DEPTH];
	// extra msb tells full from empty
	logic [FIFO_AW:0] wr_ptr;
	logic [FIFO_AW:0] rd_ptr;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr == {~rd_ptr[FIFO_AW], rd_ptr[FIFO_AW-1:0]});

	// first word falls through, head is always on dout
	assign dout = mem[rd_ptr[FIFO_AW-1:0]];

	always_ff @(posedge CORE_CLK) begin
		if (wr_en && !full)
			mem[wr_ptr[FIFO_AW-1:0]] <= din;
	end

	always_ff @(posedge CORE_CLK) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

/* rtl/arb_pkg.sv */
package arb_pkg;

	// ************************************************************
	// field widths
	// ************************************************************
	localparam int GEN_ID_W   = 32;
	localparam int WORD_ID_W  = 16;
	localparam int HASH_NUM_W = 8;
	localparam int KEY_W      = 56;
	localparam int NUM_CHARS  = 8;
	// up to 16 instances per core
	localparam int INST_W     = 4;
	// up to 4 batches in flight per core
	localparam int BATCH_W    = 2;

	// one candidate word, as written by the producer
	// chars[0] is the first character and lands in the low key bits
	typedef struct packed {
		logic                           gen_end;
		logic [GEN_ID_W-1:0]            gen_id;
		logic [WORD_ID_W-1:0]           word_id;
		logic [NUM_CHARS-1:0][7:0]      chars;
	} cand_t;

	// ID memory row
	typedef struct packed {
		logic                  key_valid;
		logic [GEN_ID_W-1:0]   gen_id;
		logic [WORD_ID_W-1:0]  word_id;
	} id_entry_t;

	// kind of core write
	typedef enum logic {
		CMD_KEY   = 1'b0,
		CMD_START = 1'b1
	} core_cmd_e;

	// key write view
	typedef struct packed {
		logic              key_valid;
		logic [KEY_W-1:0]  key;
	} core_key_t;

	// start write view, batch number in the low bits
	typedef struct packed {
		logic [KEY_W-BATCH_W:0]  zero;
		logic [BATCH_W-1:0]      batch;
	} core_start_t;

	// broadcast data word, meaning picked by core_cmd
	typedef union packed {
		core_key_t    key;
		core_start_t  start;
	} core_word_u;

	// one result per batch from a core
	typedef struct packed {
		logic [BATCH_W-1:0]     batch;
		logic                   equal;
		logic [INST_W-1:0]      inst;
		logic [HASH_NUM_W-1:0]  hash_num;
	} core_result_t;

	// output record for a match
	typedef struct packed {
		logic [GEN_ID_W-1:0]    gen_id;
		logic [WORD_ID_W-1:0]   word_id;
		logic [HASH_NUM_W-1:0]  hash_num;
	} match_rec_t;

endpackage
